// File: files.f
src/divsqrt_pkg.sv
src/divsqrt_core_if.sv
src/operand_stage.sv
src/divsqrt_ctrl.sv
src/divsqrt_core.sv
src/result_stage.sv
src/divsqrt_top.sv
tb/tb_divsqrt_scoreboard.sv
tb/tb_divsqrt_top.sv

// File: run.sh
#!/bin/sh
# Build and run the divide and square-root testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_divsqrt_top \
  -Mdir obj_dir -o sim_divsqrt
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_divsqrt)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

// File: src/divsqrt_core.sv
`timescale 1ns/10ps

module divsqrt_core import divsqrt_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  divsqrt_core_if.core core_if
);

  logic              run_q;
  logic              done_q;
  logic [CNT_W-1:0]  cnt_q;              // Iterations still to go
  logic [CNT_W-1:0]  width;
  logic              op_q;
  logic              dz_q;               // Divisor was zero
  logic [DATA_W-1:0] dq_q;               // Dividend or radicand, MSB first
  logic [DATA_W-1:0] div_q;
  logic [DATA_W-1:0] q_q;                // Quotient or root bits
  logic [DATA_W:0]   rem_q;              // Partial remainder
  logic [DATA_W-1:0] dq_nxt;
  logic [DATA_W:0]   part, trial, rem_nxt;
  logic [DATA_W+1:0] diff;
  logic              fits;               // Trial subtract did not borrow

  assign width = fmt_bits(core_if.fmt);

  // --------------------------------------------------------------------------
  // Sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;                    // Pulse by default
      if (core_if.abort) begin
        run_q <= 1'b0;
      end else if (core_if.start) begin
        run_q <= 1'b1;
        // One bit per cycle for divide, one bit pair for sqrt
        cnt_q <= (core_if.op == OP_DIV) ? width : width >> 1;
      end else if (run_q) begin
        cnt_q <= cnt_q - CNT_W'(1);
        if (cnt_q == CNT_W'(1)) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Restoring step
  // --------------------------------------------------------------------------
  always_comb begin
    if (op_q == OP_SQRT) begin
      part   = {rem_q[DATA_W-2:0], dq_q[DATA_W-1 -: 2]};   // Bring down a bit pair
      trial  = {q_q[DATA_W-2:0], 2'b01};                   // 4*root + 1
      dq_nxt = {dq_q[DATA_W-3:0], 2'b00};
    end else begin
      part   = {rem_q[DATA_W-1:0], dq_q[DATA_W-1]};        // Bring down one bit
      trial  = {1'b0, div_q};
      dq_nxt = {dq_q[DATA_W-2:0], 1'b0};
    end
    diff    = {1'b0, part} - {1'b0, trial};
    fits    = ~diff[DATA_W+1];
    rem_nxt = fits ? diff[DATA_W:0] : part;                // Restore on borrow
  end

  always_ff @(posedge clk_i) begin
    if (core_if.start) begin
      op_q  <= core_if.op;
      dz_q  <= (core_if.op == OP_DIV) && (core_if.opb == '0);
      dq_q  <= core_if.opa << (DATA_W - width);            // Align MSB to the top
      div_q <= core_if.opb;
      q_q   <= '0;
      rem_q <= '0;
    end else if (run_q) begin
      dq_q  <= dq_nxt;
      rem_q <= rem_nxt;
      q_q   <= {q_q[DATA_W-2:0], fits};
    end
  end

  // Zero divisor yields all ones since every trial fits
  assign core_if.idle   = ~run_q;
  assign core_if.done   = done_q;
  assign core_if.result = q_q;

  always_comb begin
    core_if.status            = '0;
    core_if.status[STATUS_DZ] = dz_q;
    core_if.status[STATUS_NX] = (|rem_q) & ~dz_q;          // Inexact, divide or root
  end

endmodule

// File: src/divsqrt_core_if.sv
`timescale 1ns/10ps

interface divsqrt_core_if import divsqrt_pkg::*; ();

  // Issue side, driven by the control FSM
  logic                start;            // One cycle, operands sampled here
  logic                abort;            // Drops any work in progress
  logic                op;               // OP_DIV or OP_SQRT
  logic [FMT_W-1:0]    fmt;
  logic [DATA_W-1:0]   opa;              // Dividend or radicand
  logic [DATA_W-1:0]   opb;              // Divisor

  // Completion side, driven by the core
  logic                idle;
  logic                done;             // One cycle pulse
  logic [DATA_W-1:0]   result;           // Only meaningful with done
  logic [STATUS_W-1:0] status;

  modport ctrl (
    output start, abort, op, fmt, opa, opb,
    input  idle, done, result, status
  );

  modport core (
    input  start, abort, op, fmt, opa, opb,
    output idle, done, result, status
  );

endinterface

// File: src/divsqrt_ctrl.sv
`timescale 1ns/10ps

module divsqrt_ctrl import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  // From operand stage
  input  logic                op_valid_i,
  output logic                op_ready_o,
  input  logic                op_i,
  input  logic [FMT_W-1:0]    fmt_i,
  input  logic [DATA_W-1:0]   opa_i,
  input  logic [DATA_W-1:0]   opb_i,
  // Toward result stage
  output logic                res_valid_o,
  input  logic                res_ready_i,
  input  logic                res_full_i,  // Result stage holds an item
  output logic [DATA_W-1:0]   result_o,
  output logic [STATUS_W-1:0] status_o,
  output logic                busy_o,
  divsqrt_core_if.ctrl        core_if
);

  logic [ST_W-1:0]     state_q, state_d;
  logic                free;             // Nothing left to hand downstream
  logic                hold_en;
  logic [DATA_W-1:0]   held_result_q;
  logic [STATUS_W-1:0] held_status_q;

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    free        = 1'b0;
    res_valid_o = 1'b0;
    case (state_q)
      ST_IDLE: free = 1'b1;
      ST_BUSY: begin
        if (core_if.done) begin
          res_valid_o = 1'b1;            // Offer the fresh result
          if (res_ready_i) begin
            free    = 1'b1;
            state_d = ST_IDLE;
          end else begin
            state_d = ST_HOLD;           // Park it in the hold register
          end
        end
      end
      ST_HOLD: begin
        res_valid_o = 1'b1;
        if (res_ready_i) begin
          free    = 1'b1;
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
    op_ready_o = free & core_if.idle & ~flush_i;
    if (op_valid_i && op_ready_o) state_d = ST_BUSY;   // Back to back issue
    if (flush_i) state_d = ST_IDLE;      // Flush wins over everything
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= ST_IDLE;
    else state_q <= state_d;
  end

  // Issue straight from the operand stage
  assign core_if.start = op_valid_i & op_ready_o;
  assign core_if.abort = flush_i;
  assign core_if.op    = op_i;
  assign core_if.fmt   = fmt_i;
  assign core_if.opa   = opa_i;
  assign core_if.opb   = opb_i;

  // --------------------------------------------------------------------------
  // Hold register and output select
  // --------------------------------------------------------------------------
  assign hold_en = (state_q == ST_BUSY) & core_if.done & ~res_ready_i;

  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= core_if.result;
      held_status_q <= core_if.status;
    end
  end

  assign result_o = (state_q == ST_HOLD) ? held_result_q : core_if.result;
  assign status_o = (state_q == ST_HOLD) ? held_status_q : core_if.status;

  // Any stage still holding work
  assign busy_o = op_valid_i | (state_q != ST_IDLE) | res_full_i;

  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_if.start |-> core_if.idle);

endmodule

// File: src/divsqrt_pkg.sv
package divsqrt_pkg;

  // Datapath sizes
  localparam int DATA_W   = 32;          // Widest operand and result
  localparam int FMT_W    = 2;           // Format code width
  localparam int CNT_W    = 6;           // Iteration counter, holds up to 32
  localparam int STATUS_W = 2;

  // Format codes, any unknown code runs as 32 bit
  localparam logic [FMT_W-1:0] FMT_W8  = 2'd0;
  localparam logic [FMT_W-1:0] FMT_W16 = 2'd1;
  localparam logic [FMT_W-1:0] FMT_W32 = 2'd2;

  // Operation select
  localparam logic OP_DIV  = 1'b0;
  localparam logic OP_SQRT = 1'b1;

  // Status bit positions
  localparam int STATUS_DZ = 0;          // Divide by zero
  localparam int STATUS_NX = 1;          // Remainder left over

  // Control FSM encoding
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
  localparam logic [ST_W-1:0] ST_BUSY = 2'd1;
  localparam logic [ST_W-1:0] ST_HOLD = 2'd2;

  // Operand width in bits for a format code
  function automatic logic [CNT_W-1:0] fmt_bits(input logic [FMT_W-1:0] fmt);
    case (fmt)
      FMT_W8:  fmt_bits = 6'd8;
      FMT_W16: fmt_bits = 6'd16;
      FMT_W32: fmt_bits = 6'd32;
      default: fmt_bits = 6'd32;         // Fall back to the full width
    endcase
  endfunction

endpackage

// File: src/divsqrt_top.sv
`timescale 1ns/10ps

module divsqrt_top import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                op_i,
  input  logic [FMT_W-1:0]    fmt_i,
  input  logic [DATA_W-1:0]   opa_i,
  input  logic [DATA_W-1:0]   opb_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  output logic [DATA_W-1:0]   result_o,
  output logic [STATUS_W-1:0] status_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o
);

  // Operand stage to control
  logic                op_valid, op_ready, op;
  logic [FMT_W-1:0]    fmt;
  logic [DATA_W-1:0]   opa, opb;
  // Control to result stage
  logic                res_valid, res_ready, res_full;
  logic [DATA_W-1:0]   result;
  logic [STATUS_W-1:0] status;

  divsqrt_core_if u_core_if ();

  operand_stage u_operand_stage (
    .clk_i, .rst_n_i, .flush_i, .in_valid_i, .in_ready_o, .op_i, .fmt_i, .opa_i, .opb_i,
    .op_valid_o (op_valid), .op_ready_i (op_ready),
    .op_o (op), .fmt_o (fmt), .opa_o (opa), .opb_o (opb)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i, .rst_n_i, .flush_i,
    .op_valid_i (op_valid), .op_ready_o (op_ready),
    .op_i (op), .fmt_i (fmt), .opa_i (opa), .opb_i (opb),
    .res_valid_o (res_valid), .res_ready_i (res_ready), .res_full_i (res_full),
    .result_o (result), .status_o (status), .busy_o, .core_if (u_core_if.ctrl)
  );

  divsqrt_core u_core (.clk_i, .rst_n_i, .core_if (u_core_if.core));

  result_stage u_result_stage (
    .clk_i, .rst_n_i, .flush_i,
    .res_valid_i (res_valid), .res_ready_o (res_ready),
    .result_i (result), .status_i (status),
    .out_valid_o, .out_ready_i, .result_o, .status_o, .full_o (res_full)
  );

endmodule

// File: src/operand_stage.sv
`timescale 1ns/10ps

module operand_stage import divsqrt_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  // Upstream side
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic              op_i,
  input  logic [FMT_W-1:0]  fmt_i,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  // Toward the control FSM
  output logic              op_valid_o,
  input  logic              op_ready_i,
  output logic              op_o,
  output logic [FMT_W-1:0]  fmt_o,
  output logic [DATA_W-1:0] opa_o,
  output logic [DATA_W-1:0] opb_o
);

  logic [DATA_W-1:0] width_mask;         // Ones over the selected width

  // Take a new item when empty or when the current one moves on
  assign in_ready_o = (op_ready_i | ~op_valid_o) & ~flush_i;

  assign width_mask = {DATA_W{1'b1}} >> (DATA_W - fmt_bits(fmt_i));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) op_valid_o <= 1'b0;
    else if (flush_i) op_valid_o <= 1'b0;      // Drop the held item
    else if (in_ready_o) op_valid_o <= in_valid_i;
  end

  // Payload, loaded on accept only
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      op_o  <= op_i;
      fmt_o <= fmt_i;
      opa_o <= opa_i & width_mask;       // Clean upper bits
      opb_o <= opb_i & width_mask;
    end
  end

  // Stage must be empty right after a flush
  a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !op_valid_o);

endmodule

// File: src/result_stage.sv
`timescale 1ns/10ps

module result_stage import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  // From control FSM
  input  logic                res_valid_i,
  output logic                res_ready_o,
  input  logic [DATA_W-1:0]   result_i,
  input  logic [STATUS_W-1:0] status_i,
  // Downstream side
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [DATA_W-1:0]   result_o,
  output logic [STATUS_W-1:0] status_o,
  output logic                full_o
);

  // Empty or being drained this cycle
  assign res_ready_o = ~out_valid_o | out_ready_i;
  assign full_o      = out_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) out_valid_o <= 1'b0;
    else if (flush_i) out_valid_o <= 1'b0;
    else if (res_ready_o) out_valid_o <= res_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_ready_o) begin
      result_o <= result_i;
      status_o <= status_i;
    end
  end

  // Stalled output must not move
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(status_o));

endmodule

// File: tb/tb_divsqrt_scoreboard.sv
`timescale 1ns/10ps

module tb_divsqrt_scoreboard import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  logic                in_valid_i,
  input  logic                in_ready_i,        // DUT in_ready_o
  input  logic                op_i,
  input  logic [FMT_W-1:0]    fmt_i,
  input  logic [DATA_W-1:0]   opa_i,
  input  logic [DATA_W-1:0]   opb_i,
  input  logic                out_valid_i,       // DUT out_valid_o
  input  logic                out_ready_i,
  input  logic [DATA_W-1:0]   result_i,
  input  logic [STATUS_W-1:0] status_i,
  input  logic                busy_i,            // DUT busy_o
  output int                  err_cnt_o,
  output int                  pending_o,         // Results still owed by the DUT
  output int                  checked_o
);

  logic [DATA_W-1:0]   exp_res_q[$];             // Expected results, oldest first
  logic [STATUS_W-1:0] exp_st_q[$];
  logic [DATA_W-1:0]   m_res, e_res, stall_res;
  logic [STATUS_W-1:0] m_st, e_st, stall_st;
  logic                stall_q;                  // Output refused at the last edge

  // --------------------------------------------------------------------------
  // Reference model, operands narrowed to the format width first
  // --------------------------------------------------------------------------
  function automatic void predict(input logic op, input logic [FMT_W-1:0] fmt,
                                  input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                                  output logic [DATA_W-1:0] res,
                                  output logic [STATUS_W-1:0] st);
    logic [DATA_W-1:0] mask, an, bn, root, trial;
    logic [63:0]       sq;
    int                i;
    case (fmt)
      FMT_W8:  mask = 32'h0000_00ff;
      FMT_W16: mask = 32'h0000_ffff;
      default: mask = 32'hffff_ffff;             // 32 bit and the spare code
    endcase
    an = a & mask;
    bn = b & mask;
    st = '0;
    if (op == OP_SQRT) begin
      root = '0;
      // Largest root whose square still fits under the radicand
      for (i = 15; i >= 0; i--) begin
        trial = root | (32'd1 << i);
        sq    = {32'd0, trial} * {32'd0, trial};
        if (sq <= {32'd0, an}) root = trial;
      end
      sq            = {32'd0, root} * {32'd0, root};
      res           = root;
      st[STATUS_NX] = (sq != {32'd0, an});       // Not a perfect square
    end else if (bn == '0) begin
      res           = mask;                      // All ones within the width
      st[STATUS_DZ] = 1'b1;
    end else begin
      res           = an / bn;
      st[STATUS_NX] = ((an % bn) != '0);
    end
  endfunction

  // --------------------------------------------------------------------------
  // Monitor, all signals sampled at the rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_res_q.delete();
      exp_st_q.delete();
      stall_q   = 1'b0;
      err_cnt_o = 0;
      checked_o = 0;
    end else begin
      // Busy exactly while an accepted item is still owed
      assert (busy_i === (exp_res_q.size() != 0)) else begin
        err_cnt_o++;
        $display("** Error: busy_o expected %h got %h", exp_res_q.size() != 0, busy_i);
      end
      if (stall_q) begin                         // Refused output must hold still
        assert (out_valid_i === 1'b1) else begin
          err_cnt_o++;
          $display("** Error: out_valid_o expected %h got %h", 1'b1, out_valid_i);
        end
        assert (result_i === stall_res && status_i === stall_st) else begin
          err_cnt_o++;
          $display("** Error: result_o/status_o expected %h/%h got %h/%h while stalled",
                   stall_res, stall_st, result_i, status_i);
        end
      end
      if (flush_i) begin
        assert (in_ready_i === 1'b0) else begin
          err_cnt_o++;
          $display("** Error: in_ready_o expected %h got %h during flush", 1'b0, in_ready_i);
        end
        exp_res_q.delete();                      // Everything in flight is dropped
        exp_st_q.delete();
      end else begin
        if (out_valid_i && out_ready_i) begin
          assert (exp_res_q.size() != 0) else begin
            err_cnt_o++;
            $display("A result was delivered at %0t with no item outstanding", $time);
          end
          if (exp_res_q.size() != 0) begin
            e_res = exp_res_q.pop_front();
            e_st  = exp_st_q.pop_front();
            checked_o++;
            assert (result_i === e_res) else begin
              err_cnt_o++;
              $display("** Error: result_o expected %h got %h", e_res, result_i);
            end
            assert (status_i === e_st) else begin
              err_cnt_o++;
              $display("** Error: status_o expected %h got %h", e_st, status_i);
            end
          end
        end
        if (in_valid_i && in_ready_i) begin      // Accepted input, queue its answer
          predict(op_i, fmt_i, opa_i, opb_i, m_res, m_st);
          exp_res_q.push_back(m_res);
          exp_st_q.push_back(m_st);
        end
      end
      stall_q   = out_valid_i && !out_ready_i && !flush_i;
      stall_res = result_i;
      stall_st  = status_i;
    end
    pending_o = exp_res_q.size();
  end

endmodule

// File: tb/tb_divsqrt_top.sv
`timescale 1ns/10ps

module tb_divsqrt_top import divsqrt_pkg::*; ();

  localparam int N_CYCLES  = 5000;               // Length of random stimulus
  localparam int DRAIN_MAX = 1000;               // Cycles allowed to empty the pipe

  logic                clk, rst_n, op, in_valid, in_ready, flush;
  logic                out_valid, out_ready, busy, taken, drained;
  logic [FMT_W-1:0]    fmt;
  logic [DATA_W-1:0]   opa, opb, result;
  logic [STATUS_W-1:0] status;
  integer              seed;
  int                  errors, sb_errors, pending, checked, cyc;

  divsqrt_top UUT (
    .clk_i (clk), .rst_n_i (rst_n), .op_i (op), .fmt_i (fmt), .opa_i (opa), .opb_i (opb),
    .in_valid_i (in_valid), .in_ready_o (in_ready), .flush_i (flush),
    .result_o (result), .status_o (status), .out_valid_o (out_valid),
    .out_ready_i (out_ready), .busy_o (busy)
  );

  tb_divsqrt_scoreboard u_scoreboard (
    .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush), .in_valid_i (in_valid),
    .in_ready_i (in_ready), .op_i (op), .fmt_i (fmt), .opa_i (opa), .opb_i (opb),
    .out_valid_i (out_valid), .out_ready_i (out_ready), .result_i (result),
    .status_i (status), .busy_i (busy), .err_cnt_o (sb_errors), .pending_o (pending),
    .checked_o (checked)
  );

  initial begin                                  // 40 ns clock
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // One falling edge of stimulus, a held item stays put until it is taken
  task automatic drive_random(input logic was_taken);
    logic [31:0] r;
    r         = $random(seed);
    flush     = (r[5:0] == 6'd0);                // Rare one cycle flush
    out_ready = !flush && (r[7] || r[8]);        // No drain during flush
    if (!in_valid || was_taken) begin
      in_valid = r[9] | r[10];
      op       = r[11];
      fmt      = r[13:12];                       // Spare code included
      opa      = $random(seed);
      opb      = $random(seed);
      opb      = opb >> r[18:14];                // Spread divisor sizes
      if (r[22:19] == 4'd0) opb = '0;            // Divide by zero now and then
    end
  endtask

  task automatic check_idle();
    assert (busy === 1'b0) else begin
      errors++;
      $display("** Error: busy_o expected %h got %h", 1'b0, busy);
    end
    assert (out_valid === 1'b0) else begin
      errors++;
      $display("** Error: out_valid_o expected %h got %h", 1'b0, out_valid);
    end
  endtask

  // Finish the held item and wait for every expected result, bounded
  task automatic drain_pipe(output logic ok);
    int n;
    logic done_in;
    ok        = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b1;
    for (n = 0; n < DRAIN_MAX && !ok; n++) begin
      @(posedge clk);
      done_in = in_valid && in_ready;
      @(negedge clk);
      if (done_in) in_valid = 1'b0;
      ok = !in_valid && (pending == 0);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    seed      = 32'h6667ad64;
    errors    = 0;
    rst_n     = 1'b0;
    op        = OP_DIV;
    fmt       = FMT_W8;
    opa       = '0;
    opb       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_idle();                                // State right after reset
    assert (in_ready === 1'b1) else begin
      errors++;
      $display("** Error: in_ready_o expected %h got %h", 1'b1, in_ready);
    end
    for (cyc = 0; cyc < N_CYCLES; cyc++) begin
      @(posedge clk);
      taken = in_valid && in_ready;
      @(negedge clk);
      drive_random(taken);
    end
    drain_pipe(drained);
    if (drained) check_idle();
    $display("Errors: %0d scoreboard, %0d idle checks, %0d results checked",
             sb_errors, errors, checked);
    if (drained && errors == 0 && sb_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      if (!drained) $display("Timeout: %0d results still pending after %0d cycles",
                             pending, DRAIN_MAX);
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
